/* sampler_dram_cases.txt */
# columns, hex: kind a b c d
# kind 0 early trigger: a = mask
# kind 1 load: a = instrument, b = word count (instruments in order 0, 1, 2)
# kind 2 trigger: a = mask, b = expected instrument, c = plays, d = mask pulsed mid-play
0 7 0 0 0   # before load done, dropped
1 0 5 0 0
1 1 3 0 0
1 2 7 0 0
2 1 0 1 0
2 2 1 1 0
2 4 2 1 0
2 6 1 1 0   # two bits, lowest wins
2 7 0 1 0
2 1 0 1 6   # retrigger while playing
2 4 2 1 1
2 2 1 1 4
2 0 0 0 0   # empty mask, no playback

/* sampler_dram.f */
+incdir+.
dram_bus_pkg.sv
sampler_pkg.sv
mem_client_if.sv
sync_fifo.sv
sample_loader.sv
voice_reader.sv
dram_arbiter.sv
sampler_dram_top.sv
sampler_dram_assert.sv
tb_sampler_dram.sv

/* Makefile */
TOP := tb_sampler_dram

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sampler_dram.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@! grep -q "TB FAILED" sim.log
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_sampler_dram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sampler_dram_cfg.svh"

module tb_sampler_dram;
    import dram_bus_pkg::*;
    import sampler_pkg::*;

    logic                            clk_dram_ctrl;
    logic                            rst_dram_ctrl;
    logic                            i_load_valid;
    mem_data_t                       i_load_data;
    logic                            i_load_last;
    logic                            o_load_ready;
    logic                            o_load_done;
    logic [`SAMPLER_INSTR_COUNT-1:0] i_trig;
    sample_t                         o_sample;
    logic                            o_sample_valid;
    instr_idx_t                      o_voice;
    logic                            o_mem_stb;
    logic                            o_mem_we;
    mem_addr_t                       o_mem_addr;
    mem_data_t                       o_mem_wdata;
    logic                            i_mem_stall;
    logic                            i_mem_ack;
    mem_data_t                       i_mem_rdata;

    logic [15:0] lfsr = 16'd36;
    int          cycle_count;
    int          cycle_limit;   // 0 until the cases are read
    int          error_count;
    int          test_count;
    int          test_fails;
    mem_data_t   mem_model [0:255];
    mem_data_t   load_words[$];  // stream order, address i holds word i
    bit          last_q[$];
    int          kind_q[$];
    int          arg_a[$];
    int          arg_b[$];
    int          arg_c[$];
    int          arg_d[$];
    int          words_of [`SAMPLER_INSTR_COUNT];
    int          base_of [`SAMPLER_INSTR_COUNT];
    int          due_q[$];       // ack cycle per request in flight
    mem_data_t   resp_q[$];
    logic [15:0] sample_q[$];
    int          voice_q[$];

    sampler_dram_top dut (.*);

    initial clk_dram_ctrl = 1'b0;
    always #50 clk_dram_ctrl = ~clk_dram_ctrl;

    // x^16 + x^14 + x^13 + x^11, new bit enters at the bottom
    function automatic logic random_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic mem_data_t random_word();
        mem_data_t w;
        for (int i = 0; i < `SAMPLER_DATA_W; i++) begin
            w[i] = random_bit();
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            test_fails++;
            $display("test %s: fail, %0d mismatches", name, error_count - errs_before);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_dram_ctrl);
    endtask

    task automatic pulse_trigger(input int mask);
        @(posedge clk_dram_ctrl);
        i_trig <= mask[`SAMPLER_INSTR_COUNT-1:0];
        @(posedge clk_dram_ctrl);
        i_trig <= '0;
    endtask

    always @(posedge clk_dram_ctrl) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // memory model: random stall, in-order acks 1 to 4 cycles late
    always @(posedge clk_dram_ctrl) begin : memory_model
        int lat;
        if (rst_dram_ctrl) begin
            i_mem_stall <= 1'b0;
            i_mem_ack   <= 1'b0;
            i_mem_rdata <= '0;
        end else begin
            if (o_mem_stb && !i_mem_stall) begin
                if (o_load_done) check_value("write after load done", 128'd0, 128'(o_mem_we));
                if (o_mem_we) mem_model[o_mem_addr[7:0]] = o_mem_wdata;
                lat = 1;
                if (random_bit()) lat += 1;
                if (random_bit()) lat += 2;
                due_q.push_back(cycle_count + lat);
                if (o_mem_we) resp_q.push_back('0);
                else resp_q.push_back(mem_model[o_mem_addr[7:0]]);
            end
            i_mem_ack <= 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cycle_count) begin
                i_mem_ack   <= 1'b1;
                i_mem_rdata <= resp_q.pop_front();
                void'(due_q.pop_front());
            end
            i_mem_stall <= random_bit();
        end
    end

    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl && o_sample_valid) begin
            sample_q.push_back(o_sample);
            voice_q.push_back(int'(o_voice));
        end
    end

    initial begin
        int        fd;
        string     line;
        int        f0, f1, f2, f3, f4;
        int        total;
        int        played;
        int        early_mask;
        int        early_tests;
        int        errs;
        int        k;
        int        t;
        int        exp_n;
        int        idx;
        logic [15:0] exp_s;
        rst_dram_ctrl = 1'b1;
        i_load_valid  = 1'b0;
        i_load_data   = '0;
        i_load_last   = 1'b0;
        i_trig        = '0;
        i_mem_stall   = 1'b0;
        i_mem_ack     = 1'b0;
        i_mem_rdata   = '0;
        total         = 0;
        played        = 0;
        early_mask    = 0;
        early_tests   = 0;
        fd = $fopen("sampler_dram_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 &&
                    $sscanf(line, "%h %h %h %h %h", f0, f1, f2, f3, f4) == 5) begin
                    kind_q.push_back(f0);
                    arg_a.push_back(f1);
                    arg_b.push_back(f2);
                    arg_c.push_back(f3);
                    arg_d.push_back(f4);
                end
            end
            $fclose(fd);
        end else begin
            error_count++;
            $display("cannot open case file sampler_dram_cases.txt");
        end
        foreach (kind_q[i]) begin
            if (kind_q[i] == 0) begin
                early_mask |= arg_a[i];
                early_tests++;
            end else if (kind_q[i] == 1) begin   // loads come first, in instrument order
                words_of[arg_a[i]] = arg_b[i];
                base_of[arg_a[i]]  = total;
                total += arg_b[i];
                for (int j = 0; j < arg_b[i]; j++) begin
                    load_words.push_back(random_word());
                    last_q.push_back(j == arg_b[i] - 1);
                end
            end else if (kind_q[i] == 2 && arg_c[i] != 0) begin
                played += words_of[arg_b[i]];
            end
        end
        cycle_limit = 32 * total + 64 * played + 2000;

        wait_cycles(16);
        rst_dram_ctrl <= 1'b0;

        errs = error_count;
        k    = 0;
        if (load_words.size() > 0) begin
            @(posedge clk_dram_ctrl);
            i_load_valid <= 1'b1;
            i_load_data  <= load_words[0];
            i_load_last  <= last_q[0];
            i_trig       <= early_mask[`SAMPLER_INSTR_COUNT-1:0];  // held while loading
        end
        while (k < load_words.size()) begin
            @(posedge clk_dram_ctrl);
            if (o_load_ready) begin   // beat taken at this edge
                k++;
                if (k < load_words.size()) begin
                    i_load_data <= load_words[k];
                    i_load_last <= last_q[k];
                end else begin
                    i_load_valid <= 1'b0;
                    i_trig       <= '0;
                end
            end
        end
        while (!o_load_done) @(posedge clk_dram_ctrl);
        check_value("load ready after done", 128'd0, 128'(o_load_ready));
        foreach (load_words[i]) begin
            check_value($sformatf("load word %0d", i), load_words[i], mem_model[i]);
        end
        finish_test("load", errs);

        if (early_tests > 0) begin
            errs = error_count;
            wait_cycles(40);
            check_value("early trigger sample count", 128'd0, 128'(sample_q.size()));
            finish_test("early trigger", errs);
        end

        t = 0;
        foreach (kind_q[i]) begin
            if (kind_q[i] == 2) begin
                errs = error_count;
                sample_q.delete();
                voice_q.delete();
                exp_n = (arg_c[i] != 0) ? 8 * words_of[arg_b[i]] : 0;
                pulse_trigger(arg_a[i]);
                if (exp_n > 0) begin
                    while (sample_q.size() == 0) @(posedge clk_dram_ctrl);
                    if (arg_d[i] != 0) pulse_trigger(arg_d[i]);  // must be dropped
                    while (sample_q.size() < exp_n) @(posedge clk_dram_ctrl);
                end
                wait_cycles(40);
                check_value($sformatf("trigger %0d sample count", t), 128'(exp_n),
                            128'(sample_q.size()));
                for (int j = 0; j < exp_n && j < sample_q.size(); j++) begin
                    idx   = base_of[arg_b[i]] + j / 8;
                    exp_s = load_words[idx][16 * (j % 8) +: 16];  // lane 0 first
                    check_value($sformatf("trigger %0d sample %0d", t, j), 128'(exp_s),
                                128'(sample_q[j]));
                    check_value($sformatf("trigger %0d voice %0d", t, j), 128'(arg_b[i]),
                                128'(voice_q[j]));
                end
                finish_test($sformatf("trigger %0d", t), errs);
                t++;
            end
        end

        $display("tests %0d, failed %0d, mismatches %0d", test_count, test_fails, error_count);
        if (error_count == 0 && test_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sampler_dram_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sampler_dram_cfg.svh"

// request bus rules seen at the arbiter
module sampler_dram_assert (
    input wire                       clk_dram_ctrl,
    input wire                       rst_dram_ctrl,
    input wire                       i_mem_stb,
    input wire                       i_mem_stall,
    input wire                       i_mem_we,
    input wire [`SAMPLER_ADDR_W-1:0] i_mem_addr,
    input wire [`SAMPLER_DATA_W-1:0] i_mem_wdata,
    input wire                       i_mem_ack,
    input wire                       i_tag_empty,
    input wire                       i_loader_req,
    input wire                       i_loader_grant,
    input wire                       i_voice_req,
    input wire                       i_voice_grant
);
    // stalled request keeps strobe and fields
    property hold_under_stall;
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
            i_mem_stb && i_mem_stall |=> i_mem_stb && $stable(i_mem_we)
                && $stable(i_mem_addr) && $stable(i_mem_wdata);
    endproperty

    assert property (hold_under_stall)
        else $error("request changed while the bus was stalled");

    assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_mem_ack |-> !i_tag_empty)
        else $error("memory ack with no request in flight");

    assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_loader_grant |-> i_loader_req)
        else $error("loader granted without a request");

    assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_voice_grant |-> i_voice_req)
        else $error("voice granted without a request");

endmodule

bind dram_arbiter sampler_dram_assert u_bus_assert (
    .clk_dram_ctrl  (clk_dram_ctrl),
    .rst_dram_ctrl  (rst_dram_ctrl),
    .i_mem_stb      (o_mem_stb),
    .i_mem_stall    (i_mem_stall),
    .i_mem_we       (o_mem_we),
    .i_mem_addr     (o_mem_addr),
    .i_mem_wdata    (o_mem_wdata),
    .i_mem_ack      (i_mem_ack),
    .i_tag_empty    (tag_empty),
    .i_loader_req   (loader.req),
    .i_loader_grant (loader.grant),
    .i_voice_req    (voice.req),
    .i_voice_grant  (voice.grant)
);

`default_nettype wire

/* sampler_dram_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sampler_dram_cfg.svh"

module sampler_dram_top (
    input  wire                              clk_dram_ctrl,
    input  wire                              rst_dram_ctrl,
    // instrument load stream
    input  wire                              i_load_valid,
    input  var dram_bus_pkg::mem_data_t      i_load_data,
    input  wire                              i_load_last,
    output logic                             o_load_ready,
    output logic                             o_load_done,
    // playback
    input  wire [`SAMPLER_INSTR_COUNT-1:0]   i_trig,
    output sampler_pkg::sample_t             o_sample,
    output logic                             o_sample_valid,
    output sampler_pkg::instr_idx_t          o_voice,
    // pipelined request bus to the ddr3 controller
    output logic                             o_mem_stb,
    output logic                             o_mem_we,
    output dram_bus_pkg::mem_addr_t          o_mem_addr,
    output dram_bus_pkg::mem_data_t          o_mem_wdata,
    input  wire                              i_mem_stall,
    input  wire                              i_mem_ack,
    input  var dram_bus_pkg::mem_data_t      i_mem_rdata
);
    import sampler_pkg::*;

    offset_table_t offsets;   // instrument start addresses

    mem_client_if loader_bus ();
    mem_client_if voice_bus ();

    sample_loader u_loader (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_load_valid  (i_load_valid),
        .i_load_data   (i_load_data),
        .i_load_last   (i_load_last),
        .o_load_ready  (o_load_ready),
        .o_load_done   (o_load_done),
        .o_offsets     (offsets),
        .mem           (loader_bus.client)
    );

    voice_reader u_voice (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst_dram_ctrl  (rst_dram_ctrl),
        .i_trig         (i_trig),
        .i_load_done    (o_load_done),
        .i_offsets      (offsets),
        .o_sample       (o_sample),
        .o_sample_valid (o_sample_valid),
        .o_voice        (o_voice),
        .mem            (voice_bus.client)
    );

    dram_arbiter u_arbiter (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .loader        (loader_bus.arbiter),
        .voice         (voice_bus.arbiter),
        .o_mem_stb     (o_mem_stb),
        .o_mem_we      (o_mem_we),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (o_mem_wdata),
        .i_mem_stall   (i_mem_stall),
        .i_mem_ack     (i_mem_ack),
        .i_mem_rdata   (i_mem_rdata)
    );

endmodule

`default_nettype wire

/* dram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sampler_dram_cfg.svh"

// fixed priority, loader over voice, several requests in flight
module dram_arbiter (
    input  wire                         clk_dram_ctrl,
    input  wire                         rst_dram_ctrl,
    mem_client_if.arbiter               loader,
    mem_client_if.arbiter               voice,
    output logic                        o_mem_stb,
    output logic                        o_mem_we,
    output dram_bus_pkg::mem_addr_t     o_mem_addr,
    output dram_bus_pkg::mem_data_t     o_mem_wdata,
    input  wire                         i_mem_stall,
    input  wire                         i_mem_ack,
    input  var dram_bus_pkg::mem_data_t i_mem_rdata
);
    import dram_bus_pkg::*;

    client_id_t sel_id;     // client shown on the bus this cycle
    client_id_t lock_id;
    logic       locked;     // a stalled request keeps its owner
    logic       accept;
    client_id_t ack_id;     // owner of the oldest request in flight
    logic       tag_empty;
    logic       tag_full;

    always_comb begin
        if (locked) begin
            sel_id = lock_id;
        end else if (loader.req) begin
            sel_id = CLIENT_LOADER;
        end else begin
            sel_id = CLIENT_VOICE;
        end
    end

    // no new request once every tag slot is taken
    assign o_mem_stb   = (loader.req || voice.req) && !tag_full;
    assign o_mem_we    = (sel_id == CLIENT_LOADER) ? loader.we    : voice.we;
    assign o_mem_addr  = (sel_id == CLIENT_LOADER) ? loader.addr  : voice.addr;
    assign o_mem_wdata = (sel_id == CLIENT_LOADER) ? loader.wdata : voice.wdata;

    assign accept       = o_mem_stb && !i_mem_stall;
    assign loader.grant = accept && (sel_id == CLIENT_LOADER);
    assign voice.grant  = accept && (sel_id == CLIENT_VOICE);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            locked  <= 1'b0;
            lock_id <= CLIENT_LOADER;
        end else begin
            locked  <= o_mem_stb && i_mem_stall;
            lock_id <= sel_id;
        end
    end

    sync_fifo #(
        .T     (client_id_t),
        .DEPTH (`SAMPLER_TAG_DEPTH)
    ) tag_fifo (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_push        (accept),
        .i_data        (sel_id),
        .i_pop         (i_mem_ack),
        .o_data        (ack_id),
        .o_empty       (tag_empty),
        .o_full        (tag_full)
    );

    // acks return in request order, so the head tag names the owner
    assign loader.ack   = i_mem_ack && !tag_empty && (ack_id == CLIENT_LOADER);
    assign voice.ack    = i_mem_ack && !tag_empty && (ack_id == CLIENT_VOICE);
    assign loader.rdata = i_mem_rdata;
    assign voice.rdata  = i_mem_rdata;

endmodule

`default_nettype wire

/* voice_reader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sampler_dram_cfg.svh"

// plays one instrument per trigger: reads its words, splits them into samples
module voice_reader (
    input  wire                              clk_dram_ctrl,
    input  wire                              rst_dram_ctrl,
    input  wire [`SAMPLER_INSTR_COUNT-1:0]   i_trig,
    input  wire                              i_load_done,
    input  var sampler_pkg::offset_table_t   i_offsets,
    output sampler_pkg::sample_t             o_sample,
    output logic                             o_sample_valid,
    output sampler_pkg::instr_idx_t          o_voice,
    mem_client_if.client                     mem
);
    import dram_bus_pkg::*;
    import sampler_pkg::*;

    localparam int        CRED_W    = $clog2(`SAMPLER_BUF_DEPTH + 1);
    localparam lane_idx_t LAST_LANE = lane_idx_t'(`SAMPLER_LANES - 1);

    logic              busy;
    logic              start;
    instr_idx_t        trig_idx;    // lowest set trigger bit
    mem_addr_t         rd_addr;     // next word to request
    mem_addr_t         end_addr;    // one past the instrument
    logic              issued_all;
    logic [CRED_W-1:0] credits;     // reads in flight plus buffered words
    mem_data_t         word_head;
    logic              word_empty;
    logic              load_word;
    mem_data_t         shreg;
    lane_idx_t         lane;
    logic              sh_valid;

    always_comb begin
        trig_idx = '0;
        for (int i = `SAMPLER_INSTR_COUNT - 1; i >= 0; i--) begin
            if (i_trig[i]) trig_idx = instr_idx_t'(i);
        end
    end

    assign start      = !busy && i_load_done && (|i_trig);  // otherwise dropped
    assign issued_all = (rd_addr == end_addr);

    // credits only fall while a request waits, so req stays up until grant
    assign mem.req   = busy && !issued_all && (credits < CRED_W'(`SAMPLER_BUF_DEPTH));
    assign mem.we    = 1'b0;
    assign mem.addr  = rd_addr;
    assign mem.wdata = '0;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            busy     <= 1'b0;
            o_voice  <= '0;
            rd_addr  <= '0;
            end_addr <= '0;
            credits  <= '0;
        end else begin
            if (start) begin
                busy     <= 1'b1;
                o_voice  <= trig_idx;
                rd_addr  <= i_offsets[trig_idx];
                end_addr <= i_offsets[trig_idx + 1'b1];
            end else if (busy && issued_all && credits == '0 && !sh_valid) begin
                busy <= 1'b0;  // last sample gone
            end
            if (mem.grant) rd_addr <= rd_addr + 1'b1;
            case ({mem.grant, load_word})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ;
            endcase
        end
    end

    sync_fifo #(
        .T     (mem_data_t),
        .DEPTH (`SAMPLER_BUF_DEPTH)
    ) word_fifo (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_push        (mem.ack),
        .i_data        (mem.rdata),
        .i_pop         (load_word),
        .o_data        (word_head),
        .o_empty       (word_empty),
        .o_full        ()
    );

    // next word goes in as lane 7 of the current one leaves
    assign load_word = !word_empty && (!sh_valid || lane == LAST_LANE);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            sh_valid <= 1'b0;
            lane     <= '0;
        end else if (load_word) begin
            sh_valid <= 1'b1;
            lane     <= '0;
        end else if (sh_valid) begin
            lane <= lane + 1'b1;
            if (lane == LAST_LANE) sh_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (load_word) begin
            shreg <= word_head;
        end else if (sh_valid) begin
            shreg <= shreg >> `SAMPLER_SAMPLE_W;  // lane 0 first
        end
    end

    assign o_sample       = sample_t'(shreg[`SAMPLER_SAMPLE_W-1:0]);
    assign o_sample_valid = sh_valid;

endmodule

`default_nettype wire

/* sample_loader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sampler_dram_cfg.svh"

// writes the instrument stream to memory from address 0 and records where each starts
module sample_loader (
    input  wire                        clk_dram_ctrl,
    input  wire                        rst_dram_ctrl,
    input  wire                        i_load_valid,
    input  var dram_bus_pkg::mem_data_t i_load_data,
    input  wire                        i_load_last,
    output logic                       o_load_ready,
    output logic                       o_load_done,
    output sampler_pkg::offset_table_t o_offsets,
    mem_client_if.client               mem
);
    import dram_bus_pkg::*;

    localparam int LAST_W = $clog2(`SAMPLER_INSTR_COUNT + 1);
    localparam int PEND_W = $clog2(`SAMPLER_TAG_DEPTH + 1);

    typedef struct packed {
        logic      last;
        mem_data_t data;
    } beat_t;

    beat_t             in_beat;
    beat_t             head;
    logic              buf_empty;
    logic              buf_full;
    logic              stream_open;   // low in reset and after the last instrument
    logic              take;
    logic [LAST_W-1:0] in_lasts;
    logic [LAST_W-1:0] in_lasts_nxt;
    logic [LAST_W-1:0] out_lasts;     // instruments fully written
    logic [PEND_W-1:0] pending;       // writes granted, not yet acked
    mem_addr_t         wr_addr;

    assign o_load_ready = stream_open && !buf_full;
    assign take         = i_load_valid && o_load_ready;
    assign in_beat      = '{last: i_load_last, data: i_load_data};
    assign in_lasts_nxt = in_lasts + LAST_W'(take && i_load_last);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            stream_open <= 1'b0;
            in_lasts    <= '0;
        end else begin
            stream_open <= (in_lasts_nxt < LAST_W'(`SAMPLER_INSTR_COUNT));
            in_lasts    <= in_lasts_nxt;
        end
    end

    sync_fifo #(
        .T     (beat_t),
        .DEPTH (`SAMPLER_BUF_DEPTH)
    ) beat_fifo (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_push        (take),
        .i_data        (in_beat),
        .i_pop         (mem.grant),
        .o_data        (head),
        .o_empty       (buf_empty),
        .o_full        (buf_full)
    );

    assign mem.req   = !buf_empty;
    assign mem.we    = 1'b1;
    assign mem.addr  = wr_addr;
    assign mem.wdata = head.data;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_addr     <= '0;
            out_lasts   <= '0;
            pending     <= '0;
            o_load_done <= 1'b0;
            o_offsets   <= '0;  // entry 0 stays at address 0
        end else begin
            if (mem.grant) begin
                wr_addr <= wr_addr + 1'b1;
                if (head.last) begin
                    // next instrument starts right after this word
                    o_offsets[out_lasts + 1'b1] <= wr_addr + 1'b1;
                    out_lasts                   <= out_lasts + 1'b1;
                end
            end
            case ({mem.grant, mem.ack})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: ;
            endcase
            if (out_lasts == LAST_W'(`SAMPLER_INSTR_COUNT) && pending == '0) begin
                o_load_done <= 1'b1;  // every write acknowledged
            end
        end
    end

endmodule

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sampler_dram_cfg.svh"

// register-array fifo, head visible on o_data without a pop
module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = `SAMPLER_BUF_DEPTH  // power of two
) (
    input  wire  clk_dram_ctrl,
    input  wire  rst_dram_ctrl,
    input  wire  i_push,
    input  var T i_data,
    input  wire  i_pop,
    output T     o_data,
    output logic o_empty,
    output logic o_full
);
    localparam int AW = $clog2(DEPTH);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (count == (AW+1)'(DEPTH));
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk_dram_ctrl) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* mem_client_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one client's port into the memory arbiter
interface mem_client_if;
    import dram_bus_pkg::*;

    logic      req;    // held with its fields until grant
    logic      we;     // 1 write, 0 read
    mem_addr_t addr;
    mem_data_t wdata;
    logic      grant;  // transfer cycle
    logic      ack;    // one per grant, in grant order
    mem_data_t rdata;  // valid with ack on reads

    modport client (
        output req,
        output we,
        output addr,
        output wdata,
        input  grant,
        input  ack,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output grant,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

/* sampler_pkg.sv */
`default_nettype none
`include "sampler_dram_cfg.svh"

// types of the sampler side: instruments, samples, memory layout
package sampler_pkg;

    typedef logic [$clog2(`SAMPLER_INSTR_COUNT)-1:0] instr_idx_t;

    typedef logic signed [`SAMPLER_SAMPLE_W-1:0] sample_t; // pcm, two's complement

    // position of a sample inside its memory word, lane 0 in the low bits
    typedef logic [$clog2(`SAMPLER_LANES)-1:0] lane_idx_t;

    // entry k is the start of instrument k
    // entry k+1 is one past its last word
    typedef dram_bus_pkg::mem_addr_t [`SAMPLER_INSTR_COUNT:0] offset_table_t;

endpackage

`default_nettype wire

/* dram_bus_pkg.sv */
`default_nettype none
`include "sampler_dram_cfg.svh"

// types seen on the memory request bus, by both clients and the arbiter
package dram_bus_pkg;

    // word address into the DDR3 space
    typedef logic [`SAMPLER_ADDR_W-1:0] mem_addr_t;

    typedef logic [`SAMPLER_DATA_W-1:0] mem_data_t; // one full burst word

    // owner of a request, carried as a tag while the request is in flight
    typedef enum logic {
        CLIENT_LOADER = 1'b0,
        CLIENT_VOICE  = 1'b1
    } client_id_t;

endpackage

`default_nettype wire

/* sampler_dram_cfg.svh */
`ifndef SAMPLER_DRAM_CFG_SVH
`define SAMPLER_DRAM_CFG_SVH

// one address per 128-bit memory word
`define SAMPLER_ADDR_W      24
`define SAMPLER_DATA_W      128

// audio samples packed into each memory word
`define SAMPLER_SAMPLE_W    16
`define SAMPLER_LANES       (`SAMPLER_DATA_W / `SAMPLER_SAMPLE_W) // 8 per word

`define SAMPLER_INSTR_COUNT 3

// requests in flight at the arbiter
`define SAMPLER_TAG_DEPTH   8
// word buffers in loader and voice reader, power of two
`define SAMPLER_BUF_DEPTH   8

`endif
